//--- source/msx_bus_pkg.sv
`default_nettype none

package msx_bus_pkg;

    localparam int RAM_ADDR_BITS   = 27;                 // External RAM address width
    localparam int KANJI_ADDR_BITS = 17;                 // Level-1 font ROM size, 128 KB

    // Data byte on the CPU bus and the RAM data path
    typedef logic [7:0] byte_t;

    // Byte address into the external RAM
    typedef logic [RAM_ADDR_BITS-1:0] ram_addr_t;

    // Offset inside the Kanji font image
    typedef logic [KANJI_ADDR_BITS-1:0] kanji_addr_t;

    localparam byte_t BYTE_IDLE = 8'hFF;                 // Idle level of every device output

    // Request from the CPU side, fields held until ready
    typedef struct packed {
        logic [15:0] addr;                               // Memory address or I/O port in [7:0]
        byte_t       wdata;                              // Write data
        logic        req;                                // One-cycle request strobe
        logic        wr;                                 // Write cycle
        logic        rd;                                 // Read cycle
        logic        iorq;                               // I/O space
        logic        mreq;                               // Memory space
    } cpu_req_t;

    // Response towards the CPU
    typedef struct packed {
        byte_t rdata;                                    // Valid only with ready
        logic  ready;                                    // One-cycle completion pulse
    } cpu_resp_t;

    // Request to the external RAM controller
    typedef struct packed {
        logic      cs;                                   // Held until ram_ack
        ram_addr_t addr;                                 // Stable while cs is high
    } ram_req_t;

endpackage

`default_nettype wire

//--- source/msx_device_pkg.sv
`default_nettype none

package msx_device_pkg;

    // Decoded I/O ports of the device block
    typedef enum logic [7:0] {
        KANJI_LO  = 8'hD8,                               // Index bits 10..5
        KANJI_HI  = 8'hD9,                               // Index bits 16..11, font data read
        MAPPER_P0 = 8'hFC,                               // Segment of page 0
        MAPPER_P1 = 8'hFD,
        MAPPER_P2 = 8'hFE,
        MAPPER_P3 = 8'hFF                                // Segment of page 3
    } io_port_t;

    // Bus sequencer FSM
    typedef enum logic [1:0] {
        IDLE,                                            // Waiting for req
        ACK,                                             // Single-cycle acknowledge
        FETCH,                                           // Kanji byte read from RAM
        DONE                                             // Return fetched byte
    } seq_state_t;

    // Kind of CPU request
    typedef enum logic [1:0] {
        OP_NONE,
        OP_IO_RD,
        OP_IO_WR,
        OP_MEM
    } bus_op_t;

    // Segment register values after reset, index is the page
    typedef logic [0:3][7:0] mapper_reset_t;

    localparam mapper_reset_t MAPPER_RESET = {8'd3, 8'd2, 8'd1, 8'd0};

endpackage

`default_nettype wire

//--- source/memory_mapper.sv
`default_nettype none

module memory_mapper
    import msx_bus_pkg::*, msx_device_pkg::*;
#(
    parameter int SEGMENT_BITS = 8                       // Implemented bits per register
) (
    input  wire           clock,
    input  wire           rst_n,
    input  wire cpu_req_t cpu_req,
    output byte_t         mapper_rdata,                  // Port read-back, FF when idle
    output byte_t         data_to_mapper                 // Segment of the addressed page
);

    logic [SEGMENT_BITS-1:0] segment [4];                // One register per 16 KB page

    logic port_hit;
    logic io_write;
    logic io_read;
    logic [1:0] port_page;
    logic [1:0] mem_page;

    // Unimplemented upper bits read as ones
    function automatic byte_t read_back(input logic [SEGMENT_BITS-1:0] seg);
        byte_t value;
        value = BYTE_IDLE;
        value[SEGMENT_BITS-1:0] = seg;
        return value;
    endfunction

    assign port_hit  = cpu_req.addr[7:0] inside {MAPPER_P0, MAPPER_P1, MAPPER_P2, MAPPER_P3};
    assign io_write  = cpu_req.req && cpu_req.iorq && cpu_req.wr && port_hit;
    assign io_read   = cpu_req.req && cpu_req.iorq && cpu_req.rd && port_hit;
    assign port_page = cpu_req.addr[1:0];                // FC..FF map to pages 0..3
    assign mem_page  = cpu_req.addr[15:14];

    // Segment registers
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            for (int i = 0; i < 4; i++) begin
                segment[i] <= MAPPER_RESET[i][SEGMENT_BITS-1:0];
            end
        end else if (io_write) begin
            segment[port_page] <= cpu_req.wdata[SEGMENT_BITS-1:0];
        end
    end

    // Read-back is presented for one cycle, together with ready
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            mapper_rdata <= BYTE_IDLE;
        end else if (io_read) begin
            mapper_rdata <= read_back(segment[port_page]);
        end else begin
            mapper_rdata <= BYTE_IDLE;
        end
    end

    // Page translation for the external mapper logic
    assign data_to_mapper = cpu_req.mreq ? read_back(segment[mem_page]) : BYTE_IDLE;

endmodule

`default_nettype wire

//--- source/kanji_address_counter.sv
`default_nettype none

module kanji_address_counter
    import msx_bus_pkg::*, msx_device_pkg::*;
#(
    parameter ram_addr_t KANJI_BASE = '0                 // Font image location in RAM
) (
    input  wire           clock,
    input  wire           rst_n,
    input  wire cpu_req_t cpu_req,
    input  wire           advance,                       // One pulse per font byte read
    output ram_addr_t     kanji_addr
);

    logic [5:0] index_lo;                                // Offset bits 10..5
    logic [5:0] index_hi;                                // Offset bits 16..11
    logic [4:0] row;                                     // Byte within the character

    logic        io_write;
    logic        write_lo;
    logic        write_hi;
    kanji_addr_t offset;

    assign io_write = cpu_req.req && cpu_req.iorq && cpu_req.wr;
    assign write_lo = io_write && (cpu_req.addr[7:0] == KANJI_LO);
    assign write_hi = io_write && (cpu_req.addr[7:0] == KANJI_HI);

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            index_lo <= '0;
            index_hi <= '0;
            row      <= '0;
        end else begin
            if (write_lo) begin
                index_lo <= cpu_req.wdata[5:0];
            end
            if (write_hi) begin
                index_hi <= cpu_req.wdata[5:0];
            end
            if (write_lo || write_hi) begin
                row <= '0;                               // New character starts at row 0
            end else if (advance) begin
                row <= row + 5'd1;                       // Wraps after 32 bytes
            end
        end
    end

    assign offset     = {index_hi, index_lo, row};
    assign kanji_addr = KANJI_BASE + ram_addr_t'(offset);

endmodule

`default_nettype wire

//--- source/device_bus_sequencer.sv
`default_nettype none

module device_bus_sequencer
    import msx_bus_pkg::*, msx_device_pkg::*;
(
    input  wire            clock,
    input  wire            rst_n,
    input  wire cpu_req_t  cpu_req,
    input  wire ram_addr_t kanji_addr,                   // Current font byte address
    output ram_req_t       ram,
    input  wire byte_t     ram_data,
    input  wire            ram_ack,
    output logic           ready,                        // One-cycle CPU acknowledge
    output byte_t          kanji_rdata,                  // Font byte, FF when idle
    output logic           advance                       // Row step after a fetch
);

    seq_state_t state;
    seq_state_t state_next;
    bus_op_t    op;
    logic       kanji_fetch;
    byte_t      fetch_data;                              // Byte captured on ram_ack

    // Request classification
    always_comb begin
        op = OP_NONE;
        if (cpu_req.req) begin
            if (cpu_req.iorq && cpu_req.rd) begin
                op = OP_IO_RD;
            end else if (cpu_req.iorq && cpu_req.wr) begin
                op = OP_IO_WR;
            end else begin
                op = OP_MEM;                             // Memory and anything else
            end
        end
    end

    assign kanji_fetch = (op == OP_IO_RD) && (cpu_req.addr[7:0] == KANJI_HI);

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (kanji_fetch) begin
                    state_next = FETCH;
                end else if (op != OP_NONE) begin
                    state_next = ACK;
                end
            end
            FETCH: begin
                if (ram_ack) begin
                    state_next = DONE;                   // Wait here for the RAM
                end
            end
            ACK:     state_next = IDLE;
            DONE:    state_next = IDLE;
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_ff @(posedge clock) begin
        if (state == FETCH && ram_ack) begin
            fetch_data <= ram_data;
        end
    end

    // Address comes from the counter, which holds still during the fetch
    assign ram = '{cs: (state == FETCH), addr: kanji_addr};

    assign ready       = (state == ACK) || (state == DONE);
    assign advance     = (state == DONE);
    assign kanji_rdata = (state == DONE) ? fetch_data : BYTE_IDLE;

endmodule

`default_nettype wire

//--- source/msx_devices.sv
`default_nettype none

module msx_devices
    import msx_bus_pkg::*;
#(
    parameter ram_addr_t KANJI_BASE   = 27'h0040000,     // Font image at 256 KB
    parameter int        SEGMENT_BITS = 8                // Mapper register width, 1 to 8
) (
    input  wire           clock,
    input  wire           rst_n,
    input  wire cpu_req_t cpu_req,                       // CPU bus request
    output cpu_resp_t     cpu_resp,                      // CPU bus response
    output byte_t         data_to_mapper,                // Segment for the current page
    output ram_req_t      ram,                           // External RAM request
    input  wire byte_t    ram_data,
    input  wire           ram_ack
);

    byte_t     mapper_rdata;
    byte_t     kanji_rdata;
    ram_addr_t kanji_addr;
    logic      seq_ready;
    logic      kanji_advance;

    // Idle devices drive FF, so the data outputs combine by AND
    assign cpu_resp = '{rdata: mapper_rdata & kanji_rdata, ready: seq_ready};

    memory_mapper #(
        .SEGMENT_BITS   (SEGMENT_BITS)
    ) memory_mapper (
        .clock          (clock),
        .rst_n          (rst_n),
        .cpu_req        (cpu_req),
        .mapper_rdata   (mapper_rdata),
        .data_to_mapper (data_to_mapper)
    );

    kanji_address_counter #(
        .KANJI_BASE     (KANJI_BASE)
    ) kanji_address_counter (
        .clock          (clock),
        .rst_n          (rst_n),
        .cpu_req        (cpu_req),
        .advance        (kanji_advance),
        .kanji_addr     (kanji_addr)
    );

    // Only RAM master in this block
    device_bus_sequencer device_bus_sequencer (
        .clock          (clock),
        .rst_n          (rst_n),
        .cpu_req        (cpu_req),
        .kanji_addr     (kanji_addr),
        .ram            (ram),
        .ram_data       (ram_data),
        .ram_ack        (ram_ack),
        .ready          (seq_ready),
        .kanji_rdata    (kanji_rdata),
        .advance        (kanji_advance)
    );

endmodule

`default_nettype wire

//--- verif/msx_devices_assertions.sv
`default_nettype none

module msx_devices_assertions
    import msx_bus_pkg::*;
(
    input wire            clock,
    input wire            rst_n,
    input wire cpu_req_t  cpu_req,
    input wire cpu_resp_t cpu_resp,
    input wire ram_req_t  ram,
    input wire            ram_ack
);

    timeunit 1ns;
    timeprecision 1ps;

    int   failures = 0;                                  // Read by the testbench at the end
    logic outstanding;                                   // Between req and ready

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            outstanding <= 1'b0;
        end else if (cpu_req.req) begin
            outstanding <= 1'b1;
        end else if (cpu_resp.ready) begin
            outstanding <= 1'b0;
        end
    end

    cs_held_until_ack: assert property (
        @(posedge clock) disable iff (!rst_n) ram.cs && !ram_ack |=> ram.cs
    ) else begin
        $error("ram.cs fell before ram_ack");
        failures++;
    end

    addr_stable_during_cs: assert property (
        @(posedge clock) disable iff (!rst_n) ram.cs && !ram_ack |=> $stable(ram.addr)
    ) else begin
        $error("ram.addr changed while ram.cs was high");
        failures++;
    end

    ready_single_cycle: assert property (
        @(posedge clock) disable iff (!rst_n) cpu_resp.ready |=> !cpu_resp.ready
    ) else begin
        $error("ready stayed high for more than one cycle");
        failures++;
    end

    // CPU side must wait for ready before the next strobe
    no_req_while_outstanding: assert property (
        @(posedge clock) disable iff (!rst_n) cpu_req.req |-> !outstanding
    ) else begin
        $error("req issued while a request was outstanding");
        failures++;
    end

endmodule

`default_nettype wire

//--- verif/msx_devices_tb.sv
`default_nettype none

module msx_devices_tb
    import msx_bus_pkg::*, msx_device_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int        CLK_PERIOD   = 40;
    localparam int        DRIVE_DELAY  = 2;              // Input skew after the rising edge
    localparam int        RESET_CYCLES = 5;
    localparam int        SEED         = 55137;
    localparam ram_addr_t KANJI_BASE   = 27'h0060000;
    localparam int        SEGMENT_BITS = 6;              // Leaves two read-back bits at one
    localparam byte_t     SEG_MASK     = byte_t'((1 << SEGMENT_BITS) - 1);
    localparam int        READY_LIMIT  = 8;              // Cycles before ready counts as lost

    localparam int N_MAP_WR = 12;
    localparam int N_MEM    = 20;
    localparam int N_ROW    = 40;                        // More than one full character
    localparam int N_NEW    = 3;
    localparam int N_MIX    = 150;
    localparam int N_OPS    = 8 + N_MAP_WR + 4 + N_MEM + 2 + N_ROW + 3 * N_NEW + N_MIX;
    localparam longint WATCHDOG_CYCLES = N_OPS * (6 + 4) + RESET_CYCLES;

    logic      clock;
    logic      rst_n;
    cpu_req_t  cpu_req;
    cpu_resp_t cpu_resp;
    byte_t     data_to_mapper;
    ram_req_t  ram;
    byte_t     ram_data;
    logic      ram_ack;

    int    seed     = SEED;
    int    ram_seed = SEED + 1;                          // Responder draws from its own stream
    int    checks;
    int    errors;
    int    checks_at_start;
    int    errors_at_start;
    string test_name;

    byte_t      model_seg [4];                           // Segment values, unused bits zero
    logic [5:0] model_lo;
    logic [5:0] model_hi;
    logic [4:0] model_row;

    msx_devices #(
        .KANJI_BASE     (KANJI_BASE),
        .SEGMENT_BITS   (SEGMENT_BITS)
    ) dut (
        .clock          (clock),
        .rst_n          (rst_n),
        .cpu_req        (cpu_req),
        .cpu_resp       (cpu_resp),
        .data_to_mapper (data_to_mapper),
        .ram            (ram),
        .ram_data       (ram_data),
        .ram_ack        (ram_ack)
    );

    bind msx_devices msx_devices_assertions assertions (
        .clock          (clock),
        .rst_n          (rst_n),
        .cpu_req        (cpu_req),
        .cpu_resp       (cpu_resp),
        .ram            (ram),
        .ram_ack        (ram_ack)
    );

    initial begin
        clock = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clock = ~clock;
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
        $display("Test failed");
        $finish;
    end

    // Font byte returned by the external RAM
    function automatic byte_t font_byte(input ram_addr_t addr);
        return addr[7:0] ^ addr[15:8];
    endfunction

    function automatic int rand_below(input int limit);
        return ($random(seed) & 32'h7fff_ffff) % limit;
    endfunction

    // Upper byte carries whatever the CPU had in B
    function automatic logic [15:0] io_addr(input logic [7:0] port);
        return {8'(rand_below(256)), port};
    endfunction

    function automatic logic [7:0] unmapped_port();
        logic [7:0] port;
        port = 8'(rand_below(256));
        while (port == 8'hD8 || port == 8'hD9 || port >= 8'hFC) begin
            port = 8'(rand_below(256));
        end
        return port;
    endfunction

    function automatic ram_addr_t model_fetch_addr();
        return KANJI_BASE + ram_addr_t'({model_hi, model_lo, model_row});
    endfunction

    initial begin : ram_responder
        int wait_left;
        ram_ack   = 1'b0;
        ram_data  = '0;
        wait_left = -1;
        forever begin
            @(posedge clock);
            #(DRIVE_DELAY);
            if (ram_ack) begin
                ram_ack = 1'b0;
            end else if (ram.cs) begin
                if (wait_left < 0) begin
                    wait_left = ($random(ram_seed) & 32'h7fff_ffff) % 4;  // 0 to 3 cycles
                end
                if (wait_left == 0) begin
                    ram_ack   = 1'b1;
                    ram_data  = font_byte(ram.addr);
                    wait_left = -1;
                end else begin
                    wait_left--;
                end
            end
        end
    end

    task automatic check_byte(input string what, input byte_t expected, input byte_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[FAIL] %s %s: expected %02h, actual %02h",
                     test_name, what, expected, actual);
        end
    endtask

    task automatic check_ram_addr(input string what, input ram_addr_t expected,
                                  input ram_addr_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[FAIL] %s %s: expected %07h, actual %07h",
                     test_name, what, expected, actual);
        end
    endtask

    task automatic report_error(input string text);
        errors++;
        $display("ERROR in %s: %s", test_name, text);
    endtask

    task automatic start_test(input string name);
        test_name       = name;
        checks_at_start = checks;
        errors_at_start = errors;
    endtask

    task automatic end_test();
        $display("%s done: %0d checks, %0d errors", test_name,
                 checks - checks_at_start, errors - errors_at_start);
    endtask

    task automatic update_model(input bus_op_t op, input logic [15:0] addr, input byte_t wdata);
        if (op == OP_IO_WR) begin
            if (addr[7:0] >= 8'hFC) begin
                model_seg[addr[1:0]] = wdata & SEG_MASK;
            end else if (addr[7:0] == 8'hD8) begin
                model_lo  = wdata[5:0];
                model_row = '0;
            end else if (addr[7:0] == 8'hD9) begin
                model_hi  = wdata[5:0];
                model_row = '0;
            end
        end else if (op == OP_IO_RD && addr[7:0] == 8'hD9) begin
            model_row = model_row + 5'd1;                // Wraps within the character
        end
    endtask

    // One CPU request from strobe to ready, with all checks on the way
    task automatic bus_access(input bus_op_t op, input logic [15:0] addr, input byte_t wdata);
        logic      is_read;
        logic      is_fetch;
        logic      got_ready;
        logic      cs_seen;
        int        cycles;
        int        ack_cycle;
        int        cs_cycle;
        byte_t     exp_rdata;
        byte_t     exp_mapper;
        byte_t     rdata;
        ram_addr_t exp_addr;
        ram_addr_t fetch_addr;

        is_read    = (op == OP_IO_RD);
        is_fetch   = is_read && (addr[7:0] == 8'hD9);
        exp_addr   = model_fetch_addr();
        exp_rdata  = 8'hFF;
        if (is_fetch) begin
            exp_rdata = font_byte(exp_addr);
        end else if (is_read && addr[7:0] >= 8'hFC) begin
            exp_rdata = model_seg[addr[1:0]] | ~SEG_MASK;
        end
        exp_mapper = (op == OP_MEM) ? (model_seg[addr[15:14]] | ~SEG_MASK) : 8'hFF;
        got_ready  = 1'b0;
        cs_seen    = 1'b0;
        cycles     = 0;
        ack_cycle  = -1;
        cs_cycle   = -1;
        rdata      = '0;
        fetch_addr = '0;

        cpu_req.addr  = addr;
        cpu_req.wdata = wdata;
        cpu_req.wr    = (op == OP_IO_WR);
        cpu_req.rd    = (op != OP_IO_WR);
        cpu_req.iorq  = (op == OP_IO_RD) || (op == OP_IO_WR);
        cpu_req.mreq  = (op == OP_MEM);
        cpu_req.req   = 1'b1;
        @(negedge clock);
        check_byte("data_to_mapper", exp_mapper, data_to_mapper);
        @(posedge clock);
        #(DRIVE_DELAY);
        cpu_req.req = 1'b0;

        while (!got_ready && cycles < READY_LIMIT) begin
            @(negedge clock);
            cycles++;
            if (ram.cs && !cs_seen) begin
                cs_seen    = 1'b1;
                cs_cycle   = cycles;
                fetch_addr = ram.addr;
                if (!is_fetch) begin
                    report_error("ram.cs rose for a request other than a D9 read");
                end
            end
            if (ram_ack && ack_cycle < 0) begin
                ack_cycle = cycles;
            end
            if (cpu_resp.ready) begin
                got_ready = 1'b1;
                rdata     = cpu_resp.rdata;
            end
        end

        if (!got_ready) begin
            report_error($sformatf("no ready within %0d cycles of req", READY_LIMIT));
        end else if (!is_fetch && cycles != 1) begin
            report_error($sformatf("ready came %0d cycles after req instead of 1", cycles));
        end else if (is_fetch && cycles != ack_cycle + 1) begin
            report_error($sformatf("ready in cycle %0d does not follow ram_ack in cycle %0d",
                                   cycles, ack_cycle));
        end
        if (is_fetch && !cs_seen) begin
            report_error("no RAM fetch for a D9 read");
        end else if (is_fetch) begin
            if (cs_cycle != 1) begin
                report_error($sformatf("ram.cs rose %0d cycles after req instead of 1",
                                       cs_cycle));
            end
            check_ram_addr("fetch address", exp_addr, fetch_addr);
        end
        if (is_read && got_ready) begin
            check_byte("read data", exp_rdata, rdata);
        end
        update_model(op, addr, wdata);

        @(posedge clock);
        #(DRIVE_DELAY);
        cpu_req = '0;                                    // Bus idle between requests
    endtask

    initial begin : stimulus
        logic [1:0] page;
        byte_t      data;
        int         assert_failures;

        rst_n     = 1'b0;
        cpu_req   = '0;
        checks    = 0;
        errors    = 0;
        model_seg = '{8'd3, 8'd2, 8'd1, 8'd0};
        model_lo  = '0;
        model_hi  = '0;
        model_row = '0;

        start_test("reset");
        repeat (RESET_CYCLES) @(posedge clock);
        #(DRIVE_DELAY);
        rst_n = 1'b1;
        @(negedge clock);
        checks++;
        if (cpu_resp.ready || ram.cs) begin
            report_error("ready or ram.cs high after reset");
        end
        @(posedge clock);
        #(DRIVE_DELAY);
        end_test();

        start_test("reset_values");
        for (int p = 0; p < 4; p++) begin
            bus_access(OP_IO_RD, io_addr({6'h3F, 2'(p)}), '0);
        end
        for (int i = 0; i < 4; i++) begin
            bus_access(OP_IO_RD, io_addr(unmapped_port()), '0);
        end
        end_test();

        start_test("mapper_write_read");
        for (int i = 0; i < N_MAP_WR; i++) begin
            page = 2'(rand_below(4));
            data = 8'(rand_below(256));
            bus_access(OP_IO_WR, io_addr({6'h3F, page}), data);
        end
        for (int p = 0; p < 4; p++) begin
            bus_access(OP_IO_RD, io_addr({6'h3F, 2'(p)}), '0);
        end
        end_test();

        start_test("page_translation");
        for (int i = 0; i < N_MEM; i++) begin
            bus_access(OP_MEM, 16'(rand_below(65536)), 8'(rand_below(256)));
        end
        @(negedge clock);
        check_byte("idle data_to_mapper", 8'hFF, data_to_mapper);
        @(posedge clock);
        #(DRIVE_DELAY);
        end_test();

        start_test("kanji_rows");
        bus_access(OP_IO_WR, io_addr(8'hD8), 8'(rand_below(256)));
        bus_access(OP_IO_WR, io_addr(8'hD9), 8'(rand_below(256)));
        for (int i = 0; i < N_ROW; i++) begin
            bus_access(OP_IO_RD, io_addr(8'hD9), '0);
        end
        end_test();

        start_test("kanji_new_char");
        for (int i = 0; i < N_NEW; i++) begin
            data = 8'(rand_below(256));
            bus_access(OP_IO_WR, io_addr(rand_below(2) ? 8'hD9 : 8'hD8), data);
            bus_access(OP_IO_RD, io_addr(8'hD9), '0);
            bus_access(OP_IO_RD, io_addr(8'hD9), '0);
        end
        end_test();

        start_test("mixed_random");
        for (int i = 0; i < N_MIX; i++) begin
            page = 2'(rand_below(4));
            data = 8'(rand_below(256));
            case (rand_below(7))
                0:       bus_access(OP_IO_WR, io_addr({6'h3F, page}), data);
                1:       bus_access(OP_IO_RD, io_addr({6'h3F, page}), '0);
                2:       bus_access(OP_MEM, 16'(rand_below(65536)), data);
                3:       bus_access(OP_IO_WR, io_addr(page[0] ? 8'hD9 : 8'hD8), data);
                4:       bus_access(OP_IO_RD, io_addr(8'hD9), '0);
                5:       bus_access(OP_IO_RD, io_addr(unmapped_port()), '0);
                default: bus_access(OP_IO_WR, io_addr(unmapped_port()), data);
            endcase
        end
        end_test();

        assert_failures = dut.assertions.failures;
        $display("Summary: %0d checks, %0d errors, %0d assertion failures",
                 checks, errors, assert_failures);
        if (errors == 0 && assert_failures == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
source/msx_bus_pkg.sv
source/msx_device_pkg.sv
source/memory_mapper.sv
source/kanji_address_counter.sv
source/device_bus_sequencer.sv
source/msx_devices.sv
verif/msx_devices_assertions.sv
verif/msx_devices_tb.sv
